// File: hdl/clkgen_cfg.svh
`ifndef CLKGEN_CFG_SVH
`define CLKGEN_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// Pixel clock programming widths and timing
////////////////////////////////////////////////////////////////////////////

// Board mode switches
`define CLKGEN_SW_WIDTH 4

// DFS multiply and divide values, each sent as factor minus one
`define CLKGEN_MD_WIDTH 8

// Cycles a synchronized code must hold before it counts as settled
`define CLKGEN_DEBOUNCE_CYCLES 32

// Consecutive locked cycles before the single power-up request
`define CLKGEN_POWERUP_DELAY 16

// Request to first frame
`define CLKGEN_GO_DELAY 16

// Progen low cycles between two frames
`define CLKGEN_FRAME_GAP 2

`endif

// File: hdl/clkgen_pkg.sv
`include "clkgen_cfg.svh"
`default_nettype none

package clkgen_pkg;

	////////////////////////////////////////////////////////////////////////
	// Switch codes
	////////////////////////////////////////////////////////////////////////
	typedef enum logic [`CLKGEN_SW_WIDTH-1:0] {
		vga      = 4'b0000,  // 25 MHz
		svga     = 4'b0001,  // 40 MHz
		hdtv720p = 4'b0010,  // 74.25 MHz, shares the default entry
		xga      = 4'b0011,  // 65 MHz
		sxga     = 4'b1000,  // 108 MHz
		camera   = 4'b1001
	} mode_e;

	// Frame opcode, bit 1 goes out first
	typedef enum logic [1:0] {
		op_go     = 2'b00,  // Single cycle, progdata low
		op_load_d = 2'b10,
		op_load_m = 2'b11
	} prog_op_e;

	// Frame sequencer states
	typedef enum logic [2:0] {
		idle,
		wait_go,    // Go delay running
		send_d,
		gap_d,
		send_m,
		gap_m,
		send_go,
		wait_done   // Until DFS reports progdone
	} prog_state_e;

	// Factor minus one for both values
	typedef struct packed {
		logic [`CLKGEN_MD_WIDTH-1:0] m;
		logic [`CLKGEN_MD_WIDTH-1:0] d;
	} md_pair_t;

endpackage

`default_nettype wire

// File: hdl/dcm_prog_if.sv
`timescale 1ns/100ps
`include "clkgen_cfg.svh"
`default_nettype none

interface dcm_prog_if;

	logic                        start;       // One cycle, only while shifting low
	clkgen_pkg::prog_op_e        op;          // Opcode for the frame being started
	logic [`CLKGEN_MD_WIDTH-1:0] value;       // Payload, LSB first
	logic                        shifting;    // Frame on the wire
	logic                        frame_done;  // Last progen-high cycle

	// Frame sequencer side
	modport sequencer (
		output start,
		output op,
		output value,
		input  shifting,
		input  frame_done
	);

	// Serial shifter side
	modport shifter (
		input  start,
		input  op,
		input  value,
		output shifting,
		output frame_done
	);

endinterface

`default_nettype wire

// File: hdl/switch_conditioner.sv
`timescale 1ns/100ps
`include "clkgen_cfg.svh"
`default_nettype none

module switch_conditioner (
	input  wire logic                        clk50m_bufg,
	input  wire logic                        serdes_rst,
	input  wire logic [`CLKGEN_SW_WIDTH-1:0] sw,
	output clkgen_pkg::mode_e                mode,
	output logic                             mode_changed
);

	localparam int DEB_W = $clog2(`CLKGEN_DEBOUNCE_CYCLES);
	localparam logic [DEB_W-1:0] DEB_LAST = DEB_W'(`CLKGEN_DEBOUNCE_CYCLES - 1);

	logic [`CLKGEN_SW_WIDTH-1:0] sw_meta;  // First synchronizer stage
	logic [`CLKGEN_SW_WIDTH-1:0] sw_sync;
	logic [`CLKGEN_SW_WIDTH-1:0] sw_q;     // Registered code
	logic [`CLKGEN_SW_WIDTH-1:0] cand_q;   // Code being timed
	logic [DEB_W-1:0]            deb_cnt;
	logic                        cand_held;

	////////////////////////////////////////////////////////////////////////
	// Synchronizer and register
	////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk50m_bufg or posedge serdes_rst) begin
		if (serdes_rst) begin
			sw_meta <= '0;
			sw_sync <= '0;
			sw_q    <= '0;
		end else begin
			sw_meta <= sw;
			sw_sync <= sw_meta;
			sw_q    <= sw_sync;
		end
	end

	// Candidate held for the full window
	assign cand_held = (deb_cnt == DEB_LAST);

	////////////////////////////////////////////////////////////////////////
	// Debounce counter
	////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk50m_bufg or posedge serdes_rst) begin
		if (serdes_rst) begin
			cand_q  <= '0;
			deb_cnt <= '0;
		end else if (sw_q != cand_q) begin
			cand_q  <= sw_q;  // New code, restart timing
			deb_cnt <= '0;
		end else if (!cand_held) begin
			deb_cnt <= deb_cnt + 1'b1;
		end
	end

	// Settled code differs from current mode
	always_ff @(posedge clk50m_bufg or posedge serdes_rst) begin
		if (serdes_rst) begin
			mode         <= clkgen_pkg::vga;
			mode_changed <= 1'b0;
		end else begin
			mode_changed <= 1'b0;
			if (cand_held && (cand_q != mode)) begin
				mode         <= clkgen_pkg::mode_e'(cand_q);  // Unlisted codes kept as is
				mode_changed <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/reprogram_timer.sv
`timescale 1ns/100ps
`include "clkgen_cfg.svh"
`default_nettype none

module reprogram_timer (
	input  wire logic               clk50m_bufg,
	input  wire logic               serdes_rst,
	input  wire logic               dfs_locked,
	input  wire clkgen_pkg::mode_e  mode,
	input  wire logic               mode_changed,
	output logic                    go,
	output clkgen_pkg::md_pair_t    md,
	output logic                    request
);

	localparam int MD_W  = `CLKGEN_MD_WIDTH;
	localparam int PWR_W = $clog2(`CLKGEN_POWERUP_DELAY);
	localparam int GO_W  = $clog2(`CLKGEN_GO_DELAY);

	logic [PWR_W-1:0] pwr_cnt;    // Consecutive locked cycles
	logic             pwr_done;   // Power-up request already issued
	logic             pwr_req_q;
	logic [GO_W-1:0]  go_cnt;
	logic             go_armed;

	// M/D table, HDTV720P falls into the default entry
	function automatic clkgen_pkg::md_pair_t md_lookup(input clkgen_pkg::mode_e sel);
		clkgen_pkg::md_pair_t pair;
		case (sel)
			clkgen_pkg::vga: begin
				pair.m = MD_W'(2 - 1);
				pair.d = MD_W'(4 - 1);
			end
			clkgen_pkg::svga: begin
				pair.m = MD_W'(4 - 1);
				pair.d = MD_W'(5 - 1);
			end
			clkgen_pkg::xga: begin
				pair.m = MD_W'(13 - 1);
				pair.d = MD_W'(10 - 1);
			end
			clkgen_pkg::sxga: begin
				pair.m = MD_W'(54 - 1);
				pair.d = MD_W'(25 - 1);
			end
			clkgen_pkg::camera: begin
				pair.m = MD_W'(135 - 1);
				pair.d = MD_W'(91 - 1);
			end
			default: begin
				pair.m = MD_W'(248 - 1);
				pair.d = MD_W'(167 - 1);
			end
		endcase
		return pair;
	endfunction

	////////////////////////////////////////////////////////////////////////
	// Power-up request, once per reset
	////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk50m_bufg or posedge serdes_rst) begin
		if (serdes_rst) begin
			pwr_cnt   <= '0;
			pwr_done  <= 1'b0;
			pwr_req_q <= 1'b0;
		end else begin
			pwr_req_q <= 1'b0;
			if (!dfs_locked)
				pwr_cnt <= '0;  // Lock lost, count again
			else if (pwr_cnt != PWR_W'(`CLKGEN_POWERUP_DELAY - 1))
				pwr_cnt <= pwr_cnt + 1'b1;
			else if (!pwr_done) begin
				pwr_req_q <= 1'b1;
				pwr_done  <= 1'b1;
			end
		end
	end

	assign request = pwr_req_q | mode_changed;

	// Table entry latched with every request
	always_ff @(posedge clk50m_bufg) begin
		if (request)
			md <= md_lookup(mode);
	end

	////////////////////////////////////////////////////////////////////////
	// Go delay, reloaded by each request
	////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk50m_bufg or posedge serdes_rst) begin
		if (serdes_rst) begin
			go_cnt   <= '0;
			go_armed <= 1'b0;
		end else if (request) begin
			go_cnt   <= GO_W'(`CLKGEN_GO_DELAY - 1);
			go_armed <= 1'b1;
		end else if (go_armed) begin
			if (go_cnt == '0)
				go_armed <= 1'b0;  // Fired
			else
				go_cnt <= go_cnt - 1'b1;
		end
	end

	assign go = go_armed && (go_cnt == '0);

endmodule

`default_nettype wire

// File: hdl/dcm_prog_fsm.sv
`timescale 1ns/100ps
`include "clkgen_cfg.svh"
`default_nettype none

module dcm_prog_fsm (
	input  wire logic                 clk50m_bufg,
	input  wire logic                 serdes_rst,
	input  wire logic                 request,
	input  wire logic                 go,
	input  wire clkgen_pkg::md_pair_t md,
	input  wire logic                 progdone,
	dcm_prog_if.sequencer             link,
	output logic                      abort,
	output logic                      busy
);

	localparam int GAP_W = $clog2(`CLKGEN_FRAME_GAP + 1);

	clkgen_pkg::prog_state_e state_q, state_d;
	logic [GAP_W-1:0]        gap_cnt;
	logic                    load_gap;   // Frame just ended
	logic                    gap_over;

	assign gap_over = (gap_cnt == '0) && !link.shifting;

	////////////////////////////////////////////////////////////////////////
	// Next state and frame requests
	////////////////////////////////////////////////////////////////////////
	always_comb begin
		state_d    = state_q;
		link.start = 1'b0;
		link.op    = clkgen_pkg::op_go;
		link.value = '0;
		load_gap   = 1'b0;
		case (state_q)
			clkgen_pkg::wait_go: begin
				link.op    = clkgen_pkg::op_load_d;
				link.value = md.d;
				if (go) begin
					link.start = 1'b1;
					state_d    = clkgen_pkg::send_d;
				end
			end
			clkgen_pkg::send_d: if (link.frame_done) begin
				load_gap = 1'b1;
				state_d  = clkgen_pkg::gap_d;
			end
			clkgen_pkg::gap_d: begin
				link.op    = clkgen_pkg::op_load_m;
				link.value = md.m;
				if (gap_over) begin
					link.start = 1'b1;
					state_d    = clkgen_pkg::send_m;
				end
			end
			clkgen_pkg::send_m: if (link.frame_done) begin
				load_gap = 1'b1;
				state_d  = clkgen_pkg::gap_m;
			end
			clkgen_pkg::gap_m: if (gap_over) begin
				link.start = 1'b1;  // Go command, op_go by default
				state_d    = clkgen_pkg::send_go;
			end
			clkgen_pkg::send_go: if (link.frame_done)
				state_d = clkgen_pkg::wait_done;
			clkgen_pkg::wait_done: if (progdone)
				state_d = clkgen_pkg::idle;
			default: state_d = state_q;  // Idle until a request
		endcase

		// New request restarts from the go delay
		if (request) begin
			link.start = 1'b0;
			state_d    = clkgen_pkg::wait_go;
		end
	end

	always_ff @(posedge clk50m_bufg or posedge serdes_rst) begin
		if (serdes_rst)
			state_q <= clkgen_pkg::idle;
		else
			state_q <= state_d;
	end

	// Inter-frame gap
	always_ff @(posedge clk50m_bufg or posedge serdes_rst) begin
		if (serdes_rst)
			gap_cnt <= '0;
		else if (load_gap)
			gap_cnt <= GAP_W'(`CLKGEN_FRAME_GAP - 1);
		else if (gap_cnt != '0)
			gap_cnt <= gap_cnt - 1'b1;
	end

	assign abort = request;                         // Drops progen next cycle
	assign busy  = (state_q != clkgen_pkg::idle);

endmodule

`default_nettype wire

// File: hdl/dcm_frame_shifter.sv
`timescale 1ns/100ps
`include "clkgen_cfg.svh"
`default_nettype none

module dcm_frame_shifter (
	input  wire logic   clk50m_bufg,
	input  wire logic   serdes_rst,
	dcm_prog_if.shifter link,
	input  wire logic   abort,
	output logic        progen,
	output logic        progdata
);

	// Two marker bits plus the value
	localparam int FRAME_LEN = `CLKGEN_MD_WIDTH + 2;
	localparam int CNT_W     = $clog2(FRAME_LEN);

	logic [FRAME_LEN-1:0] shift_q;   // Bit 0 on the wire
	logic [CNT_W-1:0]     bit_cnt;   // Bits left after the current one
	logic                 progen_q;
	logic                 load;

	assign load = link.start && !progen_q;

	////////////////////////////////////////////////////////////////////////
	// Frame length control
	////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk50m_bufg or posedge serdes_rst) begin
		if (serdes_rst) begin
			progen_q <= 1'b0;
			bit_cnt  <= '0;
		end else if (abort) begin
			progen_q <= 1'b0;  // Cut the frame short
			bit_cnt  <= '0;
		end else if (load) begin
			progen_q <= 1'b1;
			if (link.op == clkgen_pkg::op_go)
				bit_cnt <= '0;  // Go is one cycle
			else
				bit_cnt <= CNT_W'(FRAME_LEN - 1);
		end else if (progen_q) begin
			if (bit_cnt == '0)
				progen_q <= 1'b0;
			else
				bit_cnt <= bit_cnt - 1'b1;
		end
	end

	// Marker bit 1 first, then value LSB first
	always_ff @(posedge clk50m_bufg or posedge serdes_rst) begin
		if (serdes_rst)
			shift_q <= '0;
		else if (abort)
			shift_q <= '0;  // Drop the rest of the frame
		else if (load)
			shift_q <= {link.value, link.op[0], link.op[1]};
		else if (progen_q)
			shift_q <= shift_q >> 1;
	end

	////////////////////////////////////////////////////////////////////////
	// Programming port and link status
	////////////////////////////////////////////////////////////////////////
	assign progen          = progen_q;
	assign progdata        = shift_q[0];  // Empty once the last bit is out
	assign link.shifting   = progen_q;
	assign link.frame_done = progen_q && (bit_cnt == '0);

endmodule

`default_nettype wire

// File: hdl/pixclk_ctrl_top.sv
`timescale 1ns/100ps
`include "clkgen_cfg.svh"
`default_nettype none

module pixclk_ctrl_top (
	input  wire logic                        clk50m_bufg,
	input  wire logic                        serdes_rst,
	input  wire logic [`CLKGEN_SW_WIDTH-1:0] sw,
	input  wire logic                        dfs_locked,
	input  wire logic                        progdone,
	output logic                             progen,
	output logic                             progdata,
	output logic                             busy
);

	clkgen_pkg::mode_e    mode;          // Settled switch code
	logic                 mode_changed;
	logic                 request;       // Power-up or mode change
	logic                 go;
	clkgen_pkg::md_pair_t md;
	logic                 abort;

	// Sequencer to shifter
	dcm_prog_if link ();

	////////////////////////////////////////////////////////////////////////
	// Mode selection and request timing
	////////////////////////////////////////////////////////////////////////
	switch_conditioner switch_conditioner_inst (
		.clk50m_bufg  (clk50m_bufg),
		.serdes_rst   (serdes_rst),
		.sw           (sw),
		.mode         (mode),
		.mode_changed (mode_changed)
	);

	reprogram_timer reprogram_timer_inst (
		.clk50m_bufg  (clk50m_bufg),
		.serdes_rst   (serdes_rst),
		.dfs_locked   (dfs_locked),
		.mode         (mode),
		.mode_changed (mode_changed),
		.go           (go),
		.md           (md),
		.request      (request)
	);

	////////////////////////////////////////////////////////////////////////
	// DFS programming port
	////////////////////////////////////////////////////////////////////////
	dcm_prog_fsm dcm_prog_fsm_inst (
		.clk50m_bufg (clk50m_bufg),
		.serdes_rst  (serdes_rst),
		.request     (request),
		.go          (go),
		.md          (md),
		.progdone    (progdone),
		.link        (link.sequencer),
		.abort       (abort),
		.busy        (busy)
	);

	dcm_frame_shifter dcm_frame_shifter_inst (
		.clk50m_bufg (clk50m_bufg),
		.serdes_rst  (serdes_rst),
		.link        (link.shifter),
		.abort       (abort),
		.progen      (progen),     // Straight to the DFS
		.progdata    (progdata)
	);

endmodule

`default_nettype wire

// File: tests/pixclk_ctrl_sva.sv
`timescale 1ns/100ps
`include "clkgen_cfg.svh"
`default_nettype none

module pixclk_ctrl_sva #(
	parameter bit PORT_SIDE = 1'b1  // Bound where progdata is visible
) (
	input wire logic clk50m_bufg,
	input wire logic serdes_rst,
	input wire logic progen,
	input wire logic progdata,
	input wire logic busy,
	input wire logic load_frame,  // D or M frame accepted this cycle
	input wire logic abort
);

	localparam int FRAME_LEN = `CLKGEN_MD_WIDTH + 2;  // Marker bits and value

	generate
		if (PORT_SIDE) begin : g_port
			// Wire idle between frames
			a_data_idle: assert property (
				@(posedge clk50m_bufg) disable iff (serdes_rst)
				!progen |-> !progdata
			) else $error("progdata high while progen low");

			// Full load frame unless a new request cuts it
			a_frame_len: assert property (
				@(posedge clk50m_bufg) disable iff (serdes_rst || abort)
				load_frame |=> progen [*FRAME_LEN] ##1 !progen
			) else $error("load frame length differs from %0d cycles", FRAME_LEN);
		end else begin : g_seq
			a_busy_cover: assert property (
				@(posedge clk50m_bufg) disable iff (serdes_rst)
				progen |-> busy
			) else $error("progen high while busy low");
		end
	endgenerate

endmodule

// Shifter side, busy lives in the sequencer
bind dcm_frame_shifter pixclk_ctrl_sva #(.PORT_SIDE(1'b1)) shifter_sva_inst (
	.clk50m_bufg (clk50m_bufg),
	.serdes_rst  (serdes_rst),
	.progen      (progen),
	.progdata    (progdata),
	.busy        (1'b0),
	.load_frame  (load && (link.op != clkgen_pkg::op_go)),
	.abort       (abort)
);

// Sequencer side, shifting mirrors progen
bind dcm_prog_fsm pixclk_ctrl_sva #(.PORT_SIDE(1'b0)) fsm_sva_inst (
	.clk50m_bufg (clk50m_bufg),
	.serdes_rst  (serdes_rst),
	.progen      (link.shifting),
	.progdata    (1'b0),
	.busy        (busy),
	.load_frame  (1'b0),
	.abort       (abort)
);

`default_nettype wire

// File: tests/pixclk_ctrl_tb.sv
`timescale 1ns/100ps
`include "clkgen_cfg.svh"
`default_nettype none

module pixclk_ctrl_tb;

	localparam int RESET_CYCLES    = 10;
	localparam int DONE_DELAY      = 20;  // Synthesizer go to progdone
	localparam int FRAME_LEN       = `CLKGEN_MD_WIDTH + 2;
	localparam int FRAME_CYCLES    = 25;  // D, gap, M, gap, go
	localparam int SETTLE_CYCLES   = `CLKGEN_DEBOUNCE_CYCLES + 8;
	localparam int SEQ_WORST       = SETTLE_CYCLES + `CLKGEN_POWERUP_DELAY
	                                 + `CLKGEN_GO_DELAY + FRAME_CYCLES + DONE_DELAY;
	localparam int WAIT_LIMIT      = 2 * SEQ_WORST;
	localparam int GLITCH_WINDOW   = 200;
	localparam int HOLD_CYCLES     = 3 * DONE_DELAY;
	localparam int LOCK_LOW_CYCLES = 50;
	// Ten full sequences plus the quiet windows, doubled
	localparam int TIMEOUT_CYCLES  = 2 * (RESET_CYCLES + LOCK_LOW_CYCLES + 10 * SEQ_WORST
	                                 + GLITCH_WINDOW + HOLD_CYCLES);
	localparam int EV_D  = 1;
	localparam int EV_M  = 2;
	localparam int EV_GO = 3;

	logic                        clk50m_bufg;
	logic                        serdes_rst;
	logic [`CLKGEN_SW_WIDTH-1:0] sw;
	logic                        dfs_locked;
	logic                        progdone;
	logic                        progen;
	logic                        progdata;
	logic                        busy;

	logic [15:0] frame_bits;        // Bits of the frame on the wire
	int          run_len;
	int          go_count;
	int          partial_count;     // Frames cut short
	int          active_cycles;     // All progen-high cycles
	int          ev_kind[$];
	int          ev_val[$];
	int          go_served;
	int          done_wait;
	int          done_pulses;
	logic        hold_done    = 1'b0;
	logic        done_pending = 1'b0;
	int          check_count;
	int          error_count;
	int          cycle_count;

	pixclk_ctrl_top pixclk_ctrl_top_inst (
		.clk50m_bufg (clk50m_bufg),
		.serdes_rst  (serdes_rst),
		.sw          (sw),
		.dfs_locked  (dfs_locked),
		.progdone    (progdone),
		.progen      (progen),
		.progdata    (progdata),
		.busy        (busy)
	);

	initial clk50m_bufg = 1'b0;
	always #10 clk50m_bufg = ~clk50m_bufg;  // 50 MHz

	////////////////////////////////////////////////////////////////////////
	// Frame decoder and synthesizer model
	////////////////////////////////////////////////////////////////////////
	always @(negedge clk50m_bufg) begin
		if (progen) begin
			if (run_len < 16)
				frame_bits[run_len] = progdata;
			run_len++;
			active_cycles++;
		end else if (run_len != 0) begin
			if (run_len == FRAME_LEN && frame_bits[0]) begin
				ev_kind.push_back(frame_bits[1] ? EV_M : EV_D);  // Second marker bit
				ev_val.push_back(frame_bits[FRAME_LEN-1:2]);      // LSB came first
			end else if (run_len == 1 && !frame_bits[0]) begin
				ev_kind.push_back(EV_GO);
				ev_val.push_back(0);
				go_count++;
			end else
				partial_count++;
			run_len = 0;
		end
	end

	// Progdone some cycles after each go, held back on request
	always @(posedge clk50m_bufg) begin
		progdone <= 1'b0;
		if (go_count != go_served) begin
			go_served = go_count;
			done_wait = DONE_DELAY;
		end else if (done_wait > 0) begin
			done_wait--;
			if (done_wait == 0)
				done_pending = 1'b1;
		end
		if (done_pending && !hold_done) begin
			progdone <= 1'b1;
			done_pending = 1'b0;
			done_pulses++;
		end
	end

	always @(posedge clk50m_bufg) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			error_count++;
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			end_run(1'b1);
		end
	end

	////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////
	task automatic end_run(input bit timed_out);
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (!timed_out && error_count == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	endtask

	task automatic check_condition(input bit ok, input string msg);
		check_count++;
		assert (ok) else begin
			error_count++;
			$display("CHECK FAILED at %0t: %s", $time, msg);
		end
	endtask

	// {M, D}, each factor minus one
	function automatic logic [15:0] expected_md(input logic [3:0] code);
		case (code)
			clkgen_pkg::vga:    return {8'd1, 8'd3};
			clkgen_pkg::svga:   return {8'd3, 8'd4};
			clkgen_pkg::xga:    return {8'd12, 8'd9};
			clkgen_pkg::sxga:   return {8'd53, 8'd24};
			clkgen_pkg::camera: return {8'd134, 8'd90};
			default:            return {8'd247, 8'd166};  // Also hdtv720p
		endcase
	endfunction

	task automatic wait_for_go(input int start_go, output bit seen);
		int n;
		seen = 1'b0;
		for (n = 0; n < WAIT_LIMIT && !seen; n++) begin
			@(negedge clk50m_bufg);
			seen = (go_count > start_go);
		end
		if (!seen) begin
			error_count++;
			$display("No go command appeared within %0d cycles", WAIT_LIMIT);
		end
	endtask

	task automatic wait_for_idle();
		int n;
		for (n = 0; n < WAIT_LIMIT && busy; n++)
			@(negedge clk50m_bufg);
		if (busy) begin
			error_count++;
			$display("Busy did not fall within %0d cycles", WAIT_LIMIT);
		end
	endtask

	// Last three frames must be D, M, go
	task automatic check_sequence(input logic [3:0] code, input int start_done);
		logic [15:0] exp_md;
		int          n;
		exp_md = expected_md(code);
		n      = ev_kind.size();
		check_condition(done_pulses > start_done, "busy fell before progdone");
		check_condition(n >= 3, $sformatf("only %0d frames decoded", n));
		if (n >= 3) begin
			check_condition(ev_kind[n-3] == EV_D && ev_val[n-3] == exp_md[7:0],
				$sformatf("mode %b D kind %0d value %0d, expected %0d",
				code, ev_kind[n-3], ev_val[n-3], exp_md[7:0]));
			check_condition(ev_kind[n-2] == EV_M && ev_val[n-2] == exp_md[15:8],
				$sformatf("mode %b M kind %0d value %0d, expected %0d",
				code, ev_kind[n-2], ev_val[n-2], exp_md[15:8]));
			check_condition(ev_kind[n-1] == EV_GO,
				$sformatf("mode %b last frame kind %0d, expected go", code, ev_kind[n-1]));
		end
	endtask

	task automatic run_mode(input logic [3:0] code);
		int start_go;
		int start_done;
		bit seen;
		start_go   = go_count;
		start_done = done_pulses;
		@(posedge clk50m_bufg);
		sw <= code;
		wait_for_go(start_go, seen);
		wait_for_idle();
		check_sequence(code, start_done);
	endtask

	////////////////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////////////////
	task automatic test_reset_idle();
		int n;
		for (n = 0; n < LOCK_LOW_CYCLES; n++) begin
			@(negedge clk50m_bufg);
			check_condition(!progen && !progdata && !busy,
				$sformatf("port active without lock: progen %b progdata %b busy %b",
				progen, progdata, busy));
		end
	endtask

	task automatic test_powerup();
		int start_go;
		int start_done;
		bit seen;
		start_go   = go_count;
		start_done = done_pulses;
		@(posedge clk50m_bufg);
		dfs_locked <= 1'b1;
		wait_for_go(start_go, seen);
		wait_for_idle();
		check_sequence(clkgen_pkg::vga, start_done);
	endtask

	task automatic test_switch_modes();
		logic [3:0] codes [6];
		codes = '{clkgen_pkg::svga, clkgen_pkg::xga, clkgen_pkg::sxga,
		          clkgen_pkg::camera, clkgen_pkg::hdtv720p, 4'b0111};
		foreach (codes[i])
			run_mode(codes[i]);
	endtask

	task automatic test_progdone_hold();
		int start_go;
		int start_done;
		int n;
		bit seen;
		start_go   = go_count;
		start_done = done_pulses;
		@(posedge clk50m_bufg);
		sw        <= clkgen_pkg::vga;
		hold_done <= 1'b1;
		wait_for_go(start_go, seen);
		for (n = 0; n < HOLD_CYCLES; n++) begin
			@(negedge clk50m_bufg);
			check_condition(busy, "busy fell while progdone withheld");
		end
		@(posedge clk50m_bufg);
		hold_done <= 1'b0;
		wait_for_idle();
		check_sequence(clkgen_pkg::vga, start_done);
	endtask

	task automatic test_glitch();
		int start_active;
		int n;
		start_active = active_cycles;
		@(posedge clk50m_bufg);
		sw <= clkgen_pkg::xga;
		repeat (`CLKGEN_DEBOUNCE_CYCLES / 2) @(posedge clk50m_bufg);
		sw <= clkgen_pkg::vga;  // Back before it settles
		for (n = 0; n < GLITCH_WINDOW; n++) begin
			@(negedge clk50m_bufg);
			check_condition(!busy, "glitch started a sequence");
		end
		check_condition(active_cycles == start_active,
			$sformatf("%0d progen cycles after glitch", active_cycles - start_active));
	endtask

	task automatic test_abort();
		int start_go;
		int start_done;
		int start_partial;
		bit seen;
		start_go      = go_count;
		start_done    = done_pulses;
		start_partial = partial_count;
		@(posedge clk50m_bufg);
		sw <= clkgen_pkg::xga;
		// Second code settles during the xga M frame
		repeat (`CLKGEN_DEBOUNCE_CYCLES + 3) @(posedge clk50m_bufg);
		sw <= clkgen_pkg::sxga;
		wait_for_go(start_go, seen);
		wait_for_idle();
		check_condition(partial_count > start_partial, "no frame was cut short");
		check_condition(go_count == start_go + 1,
			$sformatf("%0d go commands, expected 1", go_count - start_go));
		check_sequence(clkgen_pkg::sxga, start_done);
	endtask

	initial begin
		serdes_rst = 1'b1;
		sw         = clkgen_pkg::vga;
		dfs_locked = 1'b0;
		progdone   = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk50m_bufg);
		serdes_rst <= 1'b0;
		test_reset_idle();
		test_powerup();
		test_switch_modes();
		test_progdone_hold();
		test_glitch();
		test_abort();
		end_run(1'b0);
	end

endmodule

`default_nettype wire

// File: build.f
+incdir+hdl
hdl/clkgen_pkg.sv
hdl/dcm_prog_if.sv
hdl/switch_conditioner.sv
hdl/reprogram_timer.sv
hdl/dcm_prog_fsm.sv
hdl/dcm_frame_shifter.sv
hdl/pixclk_ctrl_top.sv
tests/pixclk_ctrl_sva.sv
tests/pixclk_ctrl_tb.sv
